// File: bench/periph_xbar_tb.sv
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_xbar_tb;

  import periph_xbar_pkg::*;

  localparam int NB_M           = `PX_NB_MASTERS;
  localparam int NB_S           = `PX_NB_SPERIPHS;
  localparam int MP_LANE        = `PX_NB_CORES;
  localparam int HALF_PERIOD    = 10;
  localparam int RANDOM_CYCLES  = 1600;
  // roughly three times the length of all phases together
  localparam int TIMEOUT_CYCLES = 6000;
  localparam int RR_SLAVE       = 3;

  logic                  clk;
  logic                  reset;
  logic [5:0]            cluster_id;
  logic [NB_M-1:0]       in_req;
  pe_in_req_t [NB_M-1:0] in_wdata;
  logic [NB_M-1:0]       in_gnt;
  logic [NB_M-1:0]       in_rvalid;
  pe_resp_t [NB_M-1:0]   in_rdata;
  logic [NB_S-1:0]       out_req;
  pe_req_t [NB_S-1:0]    out_wdata;
  logic [NB_S-1:0]       out_gnt;
  logic [NB_S-1:0]       out_rvalid;
  pe_resp_t [NB_S-1:0]   out_rdata;
  logic                  evt_valid;
  evt_data_t             evt_data;

  // inputs applied at the next falling edge
  logic [5:0]            nxt_cluster;
  logic [NB_M-1:0]       nxt_req;
  pe_in_req_t [NB_M-1:0] nxt_wdata;
  logic [NB_S-1:0]       nxt_gnt;

  // reference model state
  int              ptr [NB_S];
  logic [NB_M-1:0] granted;
  logic [NB_S-1:0] pend;
  pe_resp_t        pend_resp [NB_S];

  logic [31:0] rng_state;
  int          cycle_cnt;
  int          cl_sel [5] = '{0, 1, 5, 12, 3};

  periph_xbar_top uut (
    .clk_i        (clk),
    .reset_i      (reset),
    .cluster_id_i (cluster_id),
    .in_req_i     (in_req),
    .in_wdata_i   (in_wdata),
    .in_gnt_o     (in_gnt),
    .in_rvalid_o  (in_rvalid),
    .in_rdata_o   (in_rdata),
    .out_req_o    (out_req),
    .out_wdata_o  (out_wdata),
    .out_gnt_i    (out_gnt),
    .out_rvalid_i (out_rvalid),
    .out_rdata_i  (out_rdata),
    .evt_valid_o  (evt_valid),
    .evt_data_o   (evt_data)
  );

  always #(HALF_PERIOD) clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TB FAILED");
      $fatal(1, "simulation stopped by the cycle limit");
    end
  end

  task automatic stop_on_mismatch(input string sig, input logic [127:0] exp_v,
                                  input logic [127:0] act_v);
    $display("FAIL time=%0t signal=%s expected=%0h actual=%0h", $time, sig, exp_v, act_v);
    $display("TB FAILED");
    $fatal(1, "first mismatch, run stopped");
  endtask

  // a master only sees a grant for a request it has raised
  assert property (@(posedge clk) disable iff (reset) ((in_gnt & ~in_req) == '0))
    else stop_on_mismatch("in_gnt_o", $sampled(in_gnt & in_req), $sampled(in_gnt));

  assert property (@(posedge clk) disable iff (reset) !evt_valid |-> (evt_data == '0))
    else stop_on_mismatch("evt_data_o", 0, $sampled(evt_data));

  assert property (@(posedge clk) disable iff (reset) (in_rvalid != '0) |-> (out_rvalid != '0))
    else stop_on_mismatch("in_rvalid_o", 0, $sampled(in_rvalid));

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // expected slave index for one lane and address
  function automatic int model_idx(input int lane, input logic [31:0] a, input int cl);
    int   top;
    int   win_lo;
    logic periph;
    top    = a[31:20];
    win_lo = `PX_CLUSTER_MIN + `PX_CLUSTER_STRIDE * cl;
    periph = (a[23:20] == 4'h2) || (a[23:20] == 4'h3);
    if (lane < `PX_NB_CORES && periph && top >= `PX_CLUSTER_MIN && top < `PX_CLUSTER_MAX &&
        !(top >= win_lo && top < win_lo + `PX_CLUSTER_STRIDE)) begin
      return `PX_SPER_EXT_ID;
    end
    if (periph && (a[31:24] == `PX_LOCAL_TOP || lane >= `PX_NB_CORES)) begin
      if (a[19:16] >= `PX_SPER_HWPE_ID) begin
        return `PX_SPER_HWPE_ID + a[15];
      end
      return a[19:16];
    end
    return `PX_SPER_EXT_ID;
  endfunction

  // address biased toward local, remote, event and hwpe classes
  function automatic logic [31:0] pick_addr();
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] a;
    int          k;
    r  = next_rand();
    r2 = next_rand();
    k  = r[15:8] % 40;
    case (r[2:0])
      3'd0, 3'd1, 3'd2: a = 32'h10200000 | (r2 & 32'h001FFFFF);
      3'd3, 3'd4: a = {12'(`PX_CLUSTER_MIN + 4 * k + 2 + r[3]), r2[19:0]};
      3'd5: a = `PX_SOC_EVT_ADDR;
      3'd6: a = {8'h10, 3'b001, r[3], 4'(6 + r[7:4] % 10), r2[15:0]};
      default: a = r2;
    endcase
    return a;
  endfunction

  task automatic check_outputs();
    int              idx [NB_M];
    logic [NB_M-1:0] exp_gnt;
    logic            found;
    int              win;
    int              w;
    pe_req_t         exp_w;
    logic            exp_rv;
    pe_resp_t        exp_rd;
    logic            exp_ev;
    exp_gnt = '0;
    for (int m = 0; m < NB_M; m++) begin
      idx[m] = model_idx(m, in_wdata[m].addr, cluster_id);
    end
    for (int s = 0; s < NB_S; s++) begin
      found = 1'b0;
      win   = 0;
      for (int k = 0; k < NB_M; k++) begin
        w = (ptr[s] + k) % NB_M;
        if (!found && in_req[w] && idx[w] == s) begin
          found = 1'b1;
          win   = w;
        end
      end
      assert (out_req[s] == found)
        else stop_on_mismatch($sformatf("out_req_o[%0d]", s), found, out_req[s]);
      if (found) begin
        exp_w.req = in_wdata[win];
        exp_w.id  = pe_id_t'(1) << win;
        assert (out_wdata[s] == exp_w)
          else stop_on_mismatch($sformatf("out_wdata_o[%0d]", s), exp_w, out_wdata[s]);
        if (out_gnt[s]) begin
          exp_gnt[win]       = 1'b1;
          ptr[s]             = (win + 1) % NB_M;
          // responder answers one cycle after the handshake
          pend[s]            = 1'b1;
          pend_resp[s].data  = in_wdata[win].data ^ pe_data_t'(s);
          pend_resp[s].id    = exp_w.id;
          pend_resp[s].opc   = 1'b0;
        end
      end
    end
    assert (in_gnt == exp_gnt) else stop_on_mismatch("in_gnt_o", exp_gnt, in_gnt);
    granted = exp_gnt;

    for (int m = 0; m < NB_M; m++) begin
      exp_rv = 1'b0;
      exp_rd = '0;
      for (int s = 0; s < NB_S; s++) begin
        if (!exp_rv && out_rvalid[s] && out_rdata[s].id[m]) begin
          exp_rv = 1'b1;
          exp_rd = out_rdata[s];
        end
      end
      assert (in_rvalid[m] == exp_rv)
        else stop_on_mismatch($sformatf("in_rvalid_o[%0d]", m), exp_rv, in_rvalid[m]);
      assert (in_rdata[m] == exp_rd)
        else stop_on_mismatch($sformatf("in_rdata_o[%0d]", m), exp_rd, in_rdata[m]);
    end

    exp_ev = in_req[MP_LANE] &&
             (idx[MP_LANE] == `PX_SPER_EVENT_ID || idx[MP_LANE] == `PX_SPER_EVENT_ID + 1) &&
             in_wdata[MP_LANE].addr == `PX_SOC_EVT_ADDR;
    assert (evt_valid == exp_ev) else stop_on_mismatch("evt_valid_o", exp_ev, evt_valid);
    assert (evt_data == (exp_ev ? in_wdata[MP_LANE].data[`PX_EVT_WIDTH-1:0] : '0))
      else stop_on_mismatch("evt_data_o",
                            exp_ev ? in_wdata[MP_LANE].data[`PX_EVT_WIDTH-1:0] : '0, evt_data);
  endtask

  // drive on the falling edge and check half way to the rising edge
  task automatic run_cycle();
    @(negedge clk);
    for (int s = 0; s < NB_S; s++) begin
      out_rvalid[s] = pend[s];
      // stale data stays on the bus while valid is low
      out_rdata[s]  = pend_resp[s];
      pend[s]       = 1'b0;
    end
    cluster_id = nxt_cluster;
    in_req     = nxt_req;
    in_wdata   = nxt_wdata;
    out_gnt    = nxt_gnt;
    #(HALF_PERIOD / 2);
    check_outputs();
  endtask

  // masters drop granted requests and may start new ones
  task automatic step_masters(input logic allow_new);
    logic [31:0] r;
    for (int m = 0; m < NB_M; m++) begin
      if (granted[m]) begin
        nxt_req[m] = 1'b0;
      end
      r = next_rand();
      if (allow_new && !nxt_req[m] && r[1:0] != 2'b00) begin
        nxt_req[m]            = 1'b1;
        nxt_wdata[m].addr     = pick_addr();
        nxt_wdata[m].data     = next_rand();
        nxt_wdata[m].we_n     = r[2];
        nxt_wdata[m].be       = r[7:4];
      end
    end
    granted = '0;
  endtask

  task automatic drain();
    nxt_gnt = '1;
    step_masters(1'b0);
    while (nxt_req != '0) begin
      run_cycle();
      step_masters(1'b0);
    end
  endtask

  task automatic send_single(input int lane, input logic [31:0] addr, input logic [31:0] data,
                             input int cl, input int exp_idx);
    logic [NB_S-1:0] exp_sel;
    drain();
    nxt_cluster               = 6'(cl);
    nxt_req                   = '0;
    nxt_req[lane]             = 1'b1;
    nxt_wdata[lane].addr      = addr;
    nxt_wdata[lane].data      = data;
    nxt_wdata[lane].we_n      = 1'b0;
    nxt_wdata[lane].be        = 4'hF;
    run_cycle();
    exp_sel          = '0;
    exp_sel[exp_idx] = 1'b1;
    assert (out_req == exp_sel) else stop_on_mismatch("out_req_o", exp_sel, out_req);
    assert (in_gnt[lane]) else stop_on_mismatch($sformatf("in_gnt_o[%0d]", lane), 1, 0);
  endtask

  task automatic random_traffic(input int n);
    logic [31:0] r;
    for (int i = 0; i < n; i++) begin
      if (i % 128 == 0) begin
        nxt_cluster = 6'(cl_sel[(i / 128) % 5]);
      end
      step_masters(1'b1);
      for (int s = 0; s < NB_S; s++) begin
        r          = next_rand();
        nxt_gnt[s] = (r[1:0] != 2'b00);
      end
      run_cycle();
    end
  endtask

  task automatic round_robin_test();
    logic [NB_M-1:0] exp_one;
    int              rr_next;
    pe_req_t         held;
    drain();
    nxt_cluster = '0;
    // every lane targets the same local slave
    for (int m = 0; m < NB_M; m++) begin
      nxt_req[m]        = 1'b1;
      nxt_wdata[m].addr = 32'h10230000 | (m << 2);
      nxt_wdata[m].data = next_rand();
      nxt_wdata[m].we_n = 1'b1;
      nxt_wdata[m].be   = 4'hF;
    end
    nxt_gnt           = '0;
    nxt_gnt[RR_SLAVE] = 1'b1;
    rr_next           = ptr[RR_SLAVE];
    for (int i = 0; i < 20; i++) begin
      run_cycle();
      exp_one          = '0;
      exp_one[rr_next] = 1'b1;
      assert (in_gnt == exp_one) else stop_on_mismatch("in_gnt_o", exp_one, in_gnt);
      rr_next = (rr_next + 1) % NB_M;
      for (int m = 0; m < NB_M; m++) begin
        if (granted[m]) begin
          nxt_wdata[m].data = next_rand();
        end
      end
      granted = '0;
    end

    // the pending request must not move while the slave stalls
    nxt_gnt[RR_SLAVE] = 1'b0;
    held.req          = nxt_wdata[rr_next];
    held.id           = '0;
    held.id[rr_next]  = 1'b1;
    repeat (8) begin
      run_cycle();
      assert (in_gnt == '0) else stop_on_mismatch("in_gnt_o", 0, in_gnt);
      assert (out_req[RR_SLAVE]) else stop_on_mismatch("out_req_o[3]", 1, 0);
      assert (out_wdata[RR_SLAVE] == held)
        else stop_on_mismatch("out_wdata_o[3]", held, out_wdata[RR_SLAVE]);
    end
    nxt_gnt[RR_SLAVE] = 1'b1;
    run_cycle();
    exp_one          = '0;
    exp_one[rr_next] = 1'b1;
    assert (in_gnt == exp_one) else stop_on_mismatch("in_gnt_o", exp_one, in_gnt);
    drain();
  endtask

  initial begin
    clk         = 1'b0;
    reset       = 1'b1;
    cycle_cnt   = 0;
    rng_state   = 32'd19;
    cluster_id  = '0;
    in_req      = '0;
    in_wdata    = '0;
    out_gnt     = '0;
    out_rvalid  = '0;
    out_rdata   = '0;
    nxt_cluster = '0;
    nxt_req     = '0;
    nxt_wdata   = '0;
    nxt_gnt     = '0;
    granted     = '0;
    pend        = '0;
    for (int s = 0; s < NB_S; s++) begin
      ptr[s]       = 0;
      pend_resp[s] = '0;
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // remote cluster windows go to EXT for cores only
    send_single(0, 32'h10230010, 32'h00000011, 1, 2);
    send_single(4, 32'h10230010, 32'h00000022, 1, 3);
    send_single(1, 32'h10250000, 32'h00000033, 0, 5);
    send_single(2, 32'h13230000, 32'h00000044, 5, 2);
    send_single(4, 32'h13230000, 32'h00000055, 5, 3);
    send_single(3, 32'h10240000, 32'h00000066, 5, 2);
    send_single(4, 32'h10240000, 32'h00000077, 5, 4);
    send_single(1, 32'h11230000, 32'h00000088, 4, 2);
    send_single(4, 32'h11230000, 32'h00000099, 4, 3);
    // bit 15 picks the second hwpe port
    send_single(0, 32'h10270000, 32'h000000AA, 0, 6);
    send_single(1, 32'h10278000, 32'h000000BB, 0, 7);
    send_single(2, 32'h102F8000, 32'h000000CC, 0, 7);
    send_single(4, 32'h103A0000, 32'h000000DD, 12, 6);
    send_single(0, 32'h10400000, 32'h000000EE, 0, 2);

    // soc event tap
    send_single(4, `PX_SOC_EVT_ADDR, 32'h1234A5C3, 5, 0);
    assert (evt_valid) else stop_on_mismatch("evt_valid_o", 1, evt_valid);
    assert (evt_data == 8'hC3) else stop_on_mismatch("evt_data_o", 8'hC3, evt_data);
    send_single(0, `PX_SOC_EVT_ADDR, 32'h1234A5C3, 0, 0);
    assert (!evt_valid) else stop_on_mismatch("evt_valid_o", 0, evt_valid);
    send_single(4, 32'h10200F04, 32'h000000F1, 0, 0);
    assert (!evt_valid) else stop_on_mismatch("evt_valid_o", 0, evt_valid);
    send_single(4, 32'h10210F00, 32'h000000F2, 0, 1);
    assert (!evt_valid) else stop_on_mismatch("evt_valid_o", 0, evt_valid);

    random_traffic(RANDOM_CYCLES);
    round_robin_test();
    drain();
    run_cycle();

    $display("TB PASSED");
    $finish;
  end

endmodule

// File: logic/periph_addr_decode.sv
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_addr_decode (
  input  logic [5:0]                                     cluster_id_i,
  input  logic [`PX_NB_MASTERS-1:0]                      in_req_i,
  input  periph_xbar_pkg::pe_in_req_t [`PX_NB_MASTERS-1:0] in_wdata_i,
  output logic [`PX_NB_MASTERS-1:0][`PX_NB_SPERIPHS-1:0] sel_req_o,
  output periph_xbar_pkg::pe_req_t [`PX_NB_MASTERS-1:0]  req_data_o,
  output logic                                           evt_valid_o,
  output periph_xbar_pkg::evt_data_t                     evt_data_o
);

  import periph_xbar_pkg::*;

  localparam int unsigned NB_M    = `PX_NB_MASTERS;
  localparam int unsigned NB_S    = `PX_NB_SPERIPHS;
  // the master-peripheral lane sits right after the cores
  localparam int unsigned MP_LANE = `PX_NB_CORES;

  localparam pe_idx_t IDX_EXT      = pe_idx_t'(`PX_SPER_EXT_ID);
  localparam pe_idx_t IDX_HWPE     = pe_idx_t'(`PX_SPER_HWPE_ID);
  localparam pe_idx_t IDX_EVENT_LO = pe_idx_t'(`PX_SPER_EVENT_ID);
  localparam pe_idx_t IDX_EVENT_HI = pe_idx_t'(`PX_SPER_EVENT_ID + 1);

  // map one address to its slave peripheral
  function automatic pe_idx_t addr_to_idx(
    input pe_addr_t   addr,
    input logic       from_core,
    input logic [5:0] cl_id
  );
    logic [11:0] win_start;
    logic [11:0] win_end;
    logic [11:0] top;
    logic [3:0]  field;
    logic        in_map;
    logic        in_own_win;
    logic        periph_space;

    // window of this cluster inside the soc map
    win_start    = `PX_CLUSTER_MIN + `PX_CLUSTER_STRIDE * cl_id;
    win_end      = win_start + `PX_CLUSTER_STRIDE;
    top          = addr[31:20];
    field        = addr[19:16];
    in_map       = (top >= `PX_CLUSTER_MIN) && (top < `PX_CLUSTER_MAX);
    in_own_win   = (top >= win_start) && (top < win_end);
    periph_space = (addr[23:20] == 4'h2) || (addr[23:20] == 4'h3);

    // peripherals of some other cluster go out through the soc bus
    if (from_core && in_map && !in_own_win && periph_space) begin
      return IDX_EXT;
    end

    // local peripherals, lane 4 always counts as local
    if (((addr[31:24] == `PX_LOCAL_TOP) || !from_core) && periph_space) begin
      // hwpe owns two ports, bit 15 picks one
      if (field >= `PX_SPER_HWPE_ID) begin
        return IDX_HWPE + pe_idx_t'(addr[15]);
      end
      return pe_idx_t'(field);
    end

    return IDX_EXT;
  endfunction

  pe_idx_t [NB_M-1:0] lane_idx;
  logic               evt_idx_hit;

  for (genvar m = 0; m < NB_M; m++) begin : gen_lane
    assign lane_idx[m] = addr_to_idx(in_wdata_i[m].addr,
                                     (m < MP_LANE) ? 1'b1 : 1'b0,
                                     cluster_id_i);

    // request passes through, tagged with the lane id
    assign req_data_o[m].req = in_wdata_i[m];
    assign req_data_o[m].id  = pe_id_t'(1) << m;

    for (genvar s = 0; s < NB_S; s++) begin : gen_sel
      assign sel_req_o[m][s] = in_req_i[m] && (lane_idx[m] == pe_idx_t'(s));
    end
  end

  // soc event tap on the master-peripheral lane
  assign evt_idx_hit = (lane_idx[MP_LANE] == IDX_EVENT_LO) ||
                       (lane_idx[MP_LANE] == IDX_EVENT_HI);

  assign evt_valid_o = in_req_i[MP_LANE] && evt_idx_hit &&
                       (in_wdata_i[MP_LANE].addr == `PX_SOC_EVT_ADDR);

  assign evt_data_o  = evt_valid_o ? in_wdata_i[MP_LANE].data[`PX_EVT_WIDTH-1:0] : '0;

endmodule

// File: logic/periph_req_arbiter.sv
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_req_arbiter (
  input  logic                                           clk_i,
  input  logic                                           reset_i,
  input  logic [`PX_NB_MASTERS-1:0][`PX_NB_SPERIPHS-1:0] sel_req_i,
  input  periph_xbar_pkg::pe_req_t [`PX_NB_MASTERS-1:0]  req_data_i,
  input  logic [`PX_NB_SPERIPHS-1:0]                     out_gnt_i,
  output logic [`PX_NB_MASTERS-1:0][`PX_NB_SPERIPHS-1:0] sel_gnt_o,
  output logic [`PX_NB_SPERIPHS-1:0]                     out_req_o,
  output periph_xbar_pkg::pe_req_t [`PX_NB_SPERIPHS-1:0] out_wdata_o
);

  localparam int unsigned NB_M  = `PX_NB_MASTERS;
  localparam int unsigned NB_S  = `PX_NB_SPERIPHS;
  localparam int unsigned PTR_W = $clog2(NB_M);

  typedef logic [PTR_W-1:0] ptr_t;

  // circular master index, input never reaches 2*NB_M
  function automatic ptr_t wrap_idx(input int unsigned v);
    if (v >= NB_M) begin
      return ptr_t'(v - NB_M);
    end
    return ptr_t'(v);
  endfunction

  for (genvar s = 0; s < NB_S; s++) begin : gen_slave
    logic [NB_M-1:0] reqs;
    logic [NB_M-1:0] gnts;
    ptr_t            ptr_q;
    ptr_t            win;
    logic            found;

    // transpose the request matrix column for this slave
    for (genvar m = 0; m < NB_M; m++) begin : gen_col
      assign reqs[m]         = sel_req_i[m][s];
      assign sel_gnt_o[m][s] = gnts[m];
    end

    // first requester at or after the pointer
    always_comb begin
      found = 1'b0;
      win   = ptr_q;
      for (int unsigned k = 0; k < NB_M; k++) begin
        if (!found && reqs[wrap_idx(ptr_q + k)]) begin
          found = 1'b1;
          win   = wrap_idx(ptr_q + k);
        end
      end
    end

    // grant only the winner, and only when the slave takes it
    always_comb begin
      gnts      = '0;
      gnts[win] = found & out_gnt_i[s];
    end

    assign out_req_o[s]   = found;
    assign out_wdata_o[s] = req_data_i[win];

    // pointer moves past the winner after a handshake, holds otherwise
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        ptr_q <= '0;
      end else if (found && out_gnt_i[s]) begin
        ptr_q <= wrap_idx(win + 1);
      end
    end
  end

endmodule

// File: logic/periph_resp_router.sv
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_resp_router (
  input  logic [`PX_NB_SPERIPHS-1:0]                      out_rvalid_i,
  input  periph_xbar_pkg::pe_resp_t [`PX_NB_SPERIPHS-1:0] out_rdata_i,
  output logic [`PX_NB_MASTERS-1:0]                       in_rvalid_o,
  output periph_xbar_pkg::pe_resp_t [`PX_NB_MASTERS-1:0]  in_rdata_o
);

  import periph_xbar_pkg::*;

  localparam int unsigned NB_M = `PX_NB_MASTERS;
  localparam int unsigned NB_S = `PX_NB_SPERIPHS;

  for (genvar m = 0; m < NB_M; m++) begin : gen_master
    logic [NB_S-1:0] hits;
    pe_resp_t        sel_rdata;

    // slaves answering this master in this cycle
    for (genvar s = 0; s < NB_S; s++) begin : gen_hit
      assign hits[s] = out_rvalid_i[s] & out_rdata_i[s].id[m];
    end

    // scan down so the lowest slave index ends up selected
    always_comb begin
      sel_rdata = '0;
      for (int j = NB_S - 1; j >= 0; j--) begin
        if (hits[j]) begin
          sel_rdata = out_rdata_i[j];
        end
      end
    end

    assign in_rvalid_o[m] = |hits;
    assign in_rdata_o[m]  = sel_rdata;
  end

endmodule

// File: logic/periph_xbar_pkg.sv
`include "periph_xbar_settings.svh"

package periph_xbar_pkg;

  // basic bus words
  typedef logic [`PX_ADDR_WIDTH-1:0] pe_addr_t;
  typedef logic [`PX_DATA_WIDTH-1:0] pe_data_t;

  // slave index and one-hot master id
  typedef logic [$clog2(`PX_NB_SPERIPHS)-1:0] pe_idx_t;
  typedef logic [`PX_NB_MASTERS-1:0]          pe_id_t;

  typedef logic [`PX_DATA_WIDTH/8-1:0] pe_be_t;

  // payload of the software soc event
  typedef logic [`PX_EVT_WIDTH-1:0] evt_data_t;

  // request as it leaves a master
  typedef struct packed {
    pe_addr_t addr;
    pe_data_t data;
    // write enable, active low as on the peripheral bus
    logic     we_n;
    pe_be_t   be;
  } pe_in_req_t;

  // request after decode, tagged with its origin
  typedef struct packed {
    pe_in_req_t req;
    pe_id_t     id;
  } pe_req_t;

  // slave response, id carries the master it belongs to
  typedef struct packed {
    pe_data_t data;
    pe_id_t   id;
    logic     opc;
  } pe_resp_t;

endpackage

// File: logic/periph_xbar_settings.svh
`ifndef PERIPH_XBAR_SETTINGS_SVH
`define PERIPH_XBAR_SETTINGS_SVH

// master and slave port counts
`define PX_NB_CORES        4
`define PX_NB_MPERIPHS     1
`define PX_NB_MASTERS      (`PX_NB_CORES + `PX_NB_MPERIPHS)
`define PX_NB_SPERIPHS     8

// bus widths
`define PX_ADDR_WIDTH      32
`define PX_DATA_WIDTH      32
`define PX_EVT_WIDTH       8

// soc cluster map, compared against addr[31:20]
`define PX_CLUSTER_MIN     12'h100
`define PX_CLUSTER_MAX     12'h1A0
`define PX_CLUSTER_STRIDE  12'h004
`define PX_LOCAL_TOP       8'h10

// peripheral indices on the slave side
`define PX_SPER_EXT_ID     2
`define PX_SPER_EVENT_ID   0
`define PX_SPER_HWPE_ID    6

// software event fifo in the soc
`define PX_SOC_EVT_ADDR    32'h10200F00

`endif

// File: logic/periph_xbar_top.sv
`timescale 1ns/1ps
`include "periph_xbar_settings.svh"

module periph_xbar_top (
  input  logic                                            clk_i,
  input  logic                                            reset_i,
  input  logic [5:0]                                      cluster_id_i,

  // master side, lanes 0..3 are cores, lane 4 is the master peripheral
  input  logic [`PX_NB_MASTERS-1:0]                       in_req_i,
  input  periph_xbar_pkg::pe_in_req_t [`PX_NB_MASTERS-1:0] in_wdata_i,
  output logic [`PX_NB_MASTERS-1:0]                       in_gnt_o,
  output logic [`PX_NB_MASTERS-1:0]                       in_rvalid_o,
  output periph_xbar_pkg::pe_resp_t [`PX_NB_MASTERS-1:0]  in_rdata_o,

  // slave peripheral side
  output logic [`PX_NB_SPERIPHS-1:0]                      out_req_o,
  output periph_xbar_pkg::pe_req_t [`PX_NB_SPERIPHS-1:0]  out_wdata_o,
  input  logic [`PX_NB_SPERIPHS-1:0]                      out_gnt_i,
  input  logic [`PX_NB_SPERIPHS-1:0]                      out_rvalid_i,
  input  periph_xbar_pkg::pe_resp_t [`PX_NB_SPERIPHS-1:0] out_rdata_i,

  // software soc event
  output logic                                            evt_valid_o,
  output periph_xbar_pkg::evt_data_t                      evt_data_o
);

  import periph_xbar_pkg::*;

  localparam int unsigned NB_M = `PX_NB_MASTERS;
  localparam int unsigned NB_S = `PX_NB_SPERIPHS;

  // master by slave request and grant matrices
  logic    [NB_M-1:0][NB_S-1:0] sel_req;
  logic    [NB_M-1:0][NB_S-1:0] sel_gnt;
  pe_req_t [NB_M-1:0]           req_data;

  periph_addr_decode i_decode (
    .cluster_id_i (cluster_id_i),
    .in_req_i     (in_req_i),
    .in_wdata_i   (in_wdata_i),
    .sel_req_o    (sel_req),
    .req_data_o   (req_data),
    .evt_valid_o  (evt_valid_o),
    .evt_data_o   (evt_data_o)
  );

  periph_req_arbiter i_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .sel_req_i   (sel_req),
    .req_data_i  (req_data),
    .out_gnt_i   (out_gnt_i),
    .sel_gnt_o   (sel_gnt),
    .out_req_o   (out_req_o),
    .out_wdata_o (out_wdata_o)
  );

  periph_resp_router i_router (
    .out_rvalid_i (out_rvalid_i),
    .out_rdata_i  (out_rdata_i),
    .in_rvalid_o  (in_rvalid_o),
    .in_rdata_o   (in_rdata_o)
  );

  // a master is granted if any slave took its request
  for (genvar m = 0; m < NB_M; m++) begin : gen_gnt
    assign in_gnt_o[m] = |sel_gnt[m];
  end

endmodule

// File: verilog.f
+incdir+logic
logic/periph_xbar_pkg.sv
logic/periph_addr_decode.sv
logic/periph_req_arbiter.sv
logic/periph_resp_router.sv
logic/periph_xbar_top.sv
bench/periph_xbar_tb.sv
